// ==== sources.f ====
aluPkg.sv
operandPrep.sv
claSlice.sv
carryLookahead.sv
barrelShifter.sv
aluCore.sv
aluStage.sv
tbAluStage.sv

// ==== Bender.yml ====
package:
  name: aluStage

sources:
  - aluPkg.sv
  - operandPrep.sv
  - claSlice.sv
  - carryLookahead.sv
  - barrelShifter.sv
  - aluCore.sv
  - aluStage.sv
  - target: test
    files:
      - tbAluStage.sv

// ==== tbAluStage.sv ====
`default_nettype none

module tbAluStage;

	import aluPkg::*;

	localparam int doneTimeout = 20;

	logic clk;
	logic reset;
	logic issue;
	aluReqT req;
	logic done;
	aluRespT resp;
	int valueErrors;
	int timeoutErrors;

	aluStage DUT (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.req(req),
		.done(done),
		.resp(resp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Expected response worked out from the operand, add, shift and flag rules
	function automatic aluRespT predictResp(aluReqT r);
		dataT x;
		dataT y;
		dataT outW;
		logic [16:0] wide;
		logic [15:0] low;
		logic [31:0] rotW;
		logic ofl;
		aluRespT e;
		x = r.invA ? ~r.a : r.a;
		y = r.invB ? ~r.b : r.b;
		outW = '0;
		ofl = 1'b0;
		case (r.op)
			opAdd: begin
				wide = {1'b0, x} + {1'b0, y} + 17'(r.cin);
				low = {1'b0, x[14:0]} + {1'b0, y[14:0]} + 16'(r.cin);
				outW = wide[15:0];
				// low[15] is the carry into bit 15, wide[16] the carry out of it
				ofl = r.sign ? (low[15] ^ wide[16]) : wide[16];
			end
			opOr: outW = x | y;
			opXor: outW = x ^ y;
			opAnd: outW = x & y;
			opRol: begin
				rotW = {x, x} << y[3:0];
				outW = rotW[31:16];
			end
			opSll: outW = x << y[3:0];
			opSra: outW = dataT'($signed(x) >>> y[3:0]);
			default: outW = x >> y[3:0];
		endcase
		e.out = outW;
		e.ofl = ofl;
		e.z = (outW == 16'h0000);
		return e;
	endfunction

	function automatic aluReqT makeReq(dataT a, dataT b, logic cin, aluOpT op,
		logic invA, logic invB, logic sign);
		aluReqT r;
		r.a = a;
		r.b = b;
		r.cin = cin;
		r.op = op;
		r.invA = invA;
		r.invB = invB;
		r.sign = sign;
		return r;
	endfunction

	function automatic dataT randWord();
		return dataT'($urandom());
	endfunction

	function automatic aluReqT randomReq();
		return makeReq(randWord(), randWord(), 1'($urandom()), aluOpT'(3'($urandom())),
			1'($urandom()), 1'($urandom()), 1'($urandom()));
	endfunction

	task automatic checkResp(string name, aluRespT expected, aluRespT actual);
		if (actual !== expected) begin
			$display("Error %s: expected out=%h ofl=%b z=%b, actual out=%h ofl=%b z=%b",
				name, expected.out, expected.ofl, expected.z,
				actual.out, actual.ofl, actual.z);
			valueErrors++;
		end
	endtask

	task automatic checkDone(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("Error %s: expected done=%b, actual done=%b", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic waitDone(string name);
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < doneTimeout) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("Timeout in %s: done never came after the issue", name);
			timeoutErrors++;
		end
	endtask

	// One request, one response, checked once done shows up
	task automatic runOne(string name, aluReqT r);
		@(posedge clk);
		#1;
		req = r;
		issue = 1'b1;
		@(posedge clk);
		#1;
		issue = 1'b0;
		waitDone(name);
		checkResp(name, predictResp(r), resp);
	endtask

	task automatic testReset();
		aluReqT r;
		r = makeReq(16'h1234, 16'h0FFF, 1'b0, opAdd, 1'b0, 1'b0, 1'b0);
		checkDone("reset", 1'b0, done);
		checkResp("reset", '0, resp);
		@(posedge clk);
		#1;
		req = r;
		issue = 1'b1;
		@(posedge clk);
		#1;
		issue = 1'b0;
		checkDone("reset pulse", 1'b1, done);
		checkResp("reset pulse", predictResp(r), resp);
		@(posedge clk);
		#1;
		checkDone("reset pulse end", 1'b0, done);
		checkResp("reset hold", predictResp(r), resp);
		@(posedge clk);
		#1;
		checkDone("reset pulse end", 1'b0, done);
	endtask

	task automatic testAdd();
		runOne("add max signed", makeReq(16'h7FFF, 16'h0001, 1'b0, opAdd, 1'b0, 1'b0, 1'b1));
		runOne("add wrap", makeReq(16'hFFFF, 16'h0001, 1'b0, opAdd, 1'b0, 1'b0, 1'b0));
		runOne("add cin wrap", makeReq(16'hFFFF, 16'h0000, 1'b1, opAdd, 1'b0, 1'b0, 1'b0));
		// Carries that have to cross every group boundary
		runOne("add groups", makeReq(16'h0FFF, 16'hF001, 1'b0, opAdd, 1'b0, 1'b0, 1'b1));
		runOne("add groups", makeReq(16'h0EEF, 16'h0111, 1'b0, opAdd, 1'b0, 1'b0, 1'b0));
		for (int i = 0; i < 24; i++) begin
			runOne("add random", makeReq(randWord(), randWord(), i[0], opAdd,
				1'b0, 1'b0, i[1]));
		end
	endtask

	task automatic testSubtract();
		dataT x;
		x = randWord();
		runOne("sub equal", makeReq(x, x, 1'b1, opAdd, 1'b0, 1'b1, 1'b1));
		runOne("sub min signed", makeReq(16'h8000, 16'h0001, 1'b1, opAdd, 1'b0, 1'b1, 1'b1));
		for (int i = 0; i < 12; i++) begin
			runOne("sub random", makeReq(randWord(), randWord(), 1'b1, opAdd,
				1'b0, 1'b1, i[0]));
			runOne("sub invA", makeReq(randWord(), randWord(), 1'b1, opAdd,
				1'b1, 1'b0, i[0]));
		end
	endtask

	task automatic testShifts();
		aluOpT shiftOps [4];
		dataT value;
		dataT upper;
		shiftOps = '{opRol, opSll, opSra, opSrl};
		foreach (shiftOps[k]) begin
			for (int amt = 0; amt < 16; amt++) begin
				value = randWord();
				upper = randWord();
				// Half of the arithmetic shifts start from a negative value
				if (amt[0])
					value[15] = 1'b1;
				runOne("shift", makeReq(value, {upper[15:4], 4'(amt)}, 1'b0,
					shiftOps[k], 1'b0, 1'b0, 1'b1));
			end
		end
	endtask

	task automatic testLogic();
		aluOpT logicOps [3];
		dataT x;
		logicOps = '{opOr, opXor, opAnd};
		for (int inv = 0; inv < 4; inv++) begin
			foreach (logicOps[k]) begin
				for (int i = 0; i < 3; i++) begin
					runOne("logic", makeReq(randWord(), randWord(), 1'b0, logicOps[k],
						inv[1], inv[0], 1'b0));
				end
			end
		end
		x = randWord();
		runOne("logic zero and", makeReq(x, x, 1'b0, opAnd, 1'b0, 1'b1, 1'b0));
		runOne("logic zero xor", makeReq(x, x, 1'b0, opXor, 1'b0, 1'b0, 1'b0));
		runOne("logic zero or", makeReq(16'hFFFF, 16'hFFFF, 1'b0, opOr, 1'b1, 1'b1, 1'b0));
	endtask

	task automatic testBackToBack();
		aluReqT prev;
		aluReqT cur;
		@(posedge clk);
		#1;
		prev = randomReq();
		req = prev;
		issue = 1'b1;
		@(posedge clk);
		#1;
		waitDone("backToBack");
		for (int i = 1; i < 24; i++) begin
			checkDone("backToBack", 1'b1, done);
			checkResp("backToBack", predictResp(prev), resp);
			cur = randomReq();
			req = cur;
			prev = cur;
			@(posedge clk);
			#1;
		end
		issue = 1'b0;
		checkDone("backToBack", 1'b1, done);
		checkResp("backToBack", predictResp(prev), resp);
		@(posedge clk);
		#1;
		checkDone("backToBack end", 1'b0, done);
	endtask

	initial begin
		valueErrors = 0;
		timeoutErrors = 0;
		void'($urandom(32'hf8288ead));
		reset = 1'b1;
		issue = 1'b0;
		req = '0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		testReset();
		testAdd();
		testSubtract();
		testShifts();
		testLogic();
		testBackToBack();

		$display("Checks finished with %0d value errors and %0d timeouts",
			valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== aluStage.sv ====
`default_nettype none

module aluStage (
	input logic clk,
	input logic reset,
	input logic issue,
	input aluPkg::aluReqT req,
	output logic done,
	output aluPkg::aluRespT resp
);

	import aluPkg::*;

	aluRespT coreResp;

	// All of the arithmetic settles within the issue cycle
	aluCore core (
		.req(req),
		.resp(coreResp)
	);

	// done follows issue by one cycle and there is no stall path,
	// so a new request may be issued on every edge
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= issue;
		end
	end

	// The response stays put between issues
	always_ff @(posedge clk) begin
		if (reset) begin
			resp <= '0;
		end else if (issue) begin
			resp <= coreResp;
		end
	end

endmodule

`default_nettype wire

// ==== aluCore.sv ====
`default_nettype none

module aluCore (
	input aluPkg::aluReqT req,
	output aluPkg::aluRespT resp
);

	import aluPkg::*;

	dataT opA;
	dataT opB;
	dataT sumWord;
	dataT shifted;
	dataT result;
	pgGroupT [groupCount-1:0] groups;
	groupOutT [groupCount-1:0] sliceRes;
	logic [groupCount-1:0] sliceCin;
	logic [groupCount-1:0] groupP;
	logic [groupCount-1:0] groupG;
	logic [groupCount-2:0] groupCarry;
	logic ofl;

	operandPrep prep (
		.a(req.a),
		.b(req.b),
		.invA(req.invA),
		.invB(req.invB),
		.opA(opA),
		.opB(opB),
		.groups(groups)
	);

	// Group 0 takes the request carry directly, the others come from the lookahead
	assign sliceCin = {groupCarry, req.cin};

	for (genvar i = 0; i < groupCount; i++) begin : genSlice
		claSlice slice (
			.pg(groups[i]),
			.cin(sliceCin[i]),
			.res(sliceRes[i])
		);

		assign sumWord[i*groupWidth +: groupWidth] = sliceRes[i].sum;
		assign groupP[i] = sliceRes[i].groupP;
		assign groupG[i] = sliceRes[i].groupG;
	end

	// The word carry-out is also reported by the top slice, which the flags use
	carryLookahead lookahead (
		.groupP(groupP),
		.groupG(groupG),
		.cin(req.cin),
		.groupCarry(groupCarry),
		.cout()
	);

	barrelShifter shifter (
		.value(opA),
		.amount(opB[shiftWidth-1:0]),
		.op(req.op),
		.shifted(shifted)
	);

	always_comb begin
		ofl = 1'b0;
		case (req.op)
			opAdd: begin
				result = sumWord;
				// Signed overflow when the carries into and out of bit 15 differ
				ofl = req.sign
					? (sliceRes[groupCount-1].carryIntoTop ^ sliceRes[groupCount-1].carryOut)
					: sliceRes[groupCount-1].carryOut;
			end
			opOr: result = opA | opB;
			opXor: result = opA ^ opB;
			opAnd: result = opA & opB;
			default: result = shifted;
		endcase
	end

	assign resp = '{out: result, ofl: ofl, z: (result == '0)};

endmodule

`default_nettype wire

// ==== barrelShifter.sv ====
`default_nettype none

module barrelShifter (
	input aluPkg::dataT value,
	input logic [aluPkg::shiftWidth-1:0] amount,
	input aluPkg::aluOpT op,
	output aluPkg::dataT shifted
);

	import aluPkg::*;

	// stageVal[0] is the input, stageVal[shiftWidth] the final result
	dataT stageVal [shiftWidth+1];

	assign stageVal[0] = value;

	// Stage s moves the word by 2**s when amount[s] is set
	for (genvar s = 0; s < shiftWidth; s++) begin : genStage
		dataT moved;

		always_comb begin
			case (op)
				opRol: begin
					moved = {stageVal[s][dataWidth-(2**s)-1:0],
						stageVal[s][dataWidth-1 -: (2**s)]};
				end
				opSll: begin
					moved = {stageVal[s][dataWidth-(2**s)-1:0], {(2**s){1'b0}}};
				end
				opSra: begin
					// The sign bit survives every stage, so it is always the fill
					moved = {{(2**s){stageVal[s][dataWidth-1]}},
						stageVal[s][dataWidth-1:(2**s)]};
				end
				default: begin
					// Logical right shift, and also what the adder opcodes see
					moved = {{(2**s){1'b0}}, stageVal[s][dataWidth-1:(2**s)]};
				end
			endcase
		end

		assign stageVal[s+1] = amount[s] ? moved : stageVal[s];
	end

	assign shifted = stageVal[shiftWidth];

endmodule

`default_nettype wire

// ==== carryLookahead.sv ====
`default_nettype none

module carryLookahead (
	input logic [aluPkg::groupCount-1:0] groupP,
	input logic [aluPkg::groupCount-1:0] groupG,
	input logic cin,
	output logic [aluPkg::groupCount-2:0] groupCarry,
	output logic cout
);

	// Same equations as inside a slice, applied to whole groups
	// groupCarry[0] feeds group 1, groupCarry[2] feeds group 3
	assign groupCarry[0] = groupG[0]
		| (groupP[0] & cin);

	assign groupCarry[1] = groupG[1]
		| (groupP[1] & groupG[0])
		| (groupP[1] & groupP[0] & cin);

	assign groupCarry[2] = groupG[2]
		| (groupP[2] & groupG[1])
		| (groupP[2] & groupP[1] & groupG[0])
		| (groupP[2] & groupP[1] & groupP[0] & cin);

	// Carry out of the whole 16-bit word
	assign cout = groupG[3]
		| (groupP[3] & groupG[2])
		| (groupP[3] & groupP[2] & groupG[1])
		| (groupP[3] & groupP[2] & groupP[1] & groupG[0])
		| (groupP[3] & groupP[2] & groupP[1] & groupP[0] & cin);

endmodule

`default_nettype wire

// ==== claSlice.sv ====
`default_nettype none

module claSlice (
	input aluPkg::pgGroupT pg,
	input logic cin,
	output aluPkg::groupOutT res
);

	import aluPkg::*;

	logic [groupWidth-1:0] p;
	logic [groupWidth-1:0] g;
	logic [groupWidth-1:0] carry;
	logic groupP;
	logic groupG;

	assign p = pg.p;
	assign g = pg.g;

	// Every carry is expanded from cin so nothing ripples inside the group
	assign carry[0] = cin;
	assign carry[1] = g[0]
		| (p[0] & cin);
	assign carry[2] = g[1]
		| (p[1] & g[0])
		| (p[1] & p[0] & cin);
	assign carry[3] = g[2]
		| (p[2] & g[1])
		| (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & cin);

	// Group terms for the second lookahead level
	assign groupP = &p;
	assign groupG = g[3]
		| (p[3] & g[2])
		| (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]);

	assign res.sum = p ^ carry;
	assign res.groupP = groupP;
	assign res.groupG = groupG;

	// Carry out of bit 3, needed by the top slice for overflow
	assign res.carryOut = groupG | (groupP & cin);

	// Carry into bit 3, the other half of the signed overflow test
	assign res.carryIntoTop = carry[3];

endmodule

`default_nettype wire

// ==== operandPrep.sv ====
`default_nettype none

module operandPrep (
	input aluPkg::dataT a,
	input aluPkg::dataT b,
	input logic invA,
	input logic invB,
	output aluPkg::dataT opA,
	output aluPkg::dataT opB,
	output aluPkg::pgGroupT [aluPkg::groupCount-1:0] groups
);

	import aluPkg::*;

	dataT bitP;
	dataT bitG;

	// Inverting B with a carry-in of one turns the adder into a subtractor
	assign opA = invA ? ~a : a;
	assign opB = invB ? ~b : b;

	// Half-adder terms for every bit position
	assign bitP = opA ^ opB;
	assign bitG = opA & opB;

	// Pack the terms into one bundle per lookahead slice
	for (genvar i = 0; i < groupCount; i++) begin : genGroup
		assign groups[i].p = bitP[i*groupWidth +: groupWidth];
		assign groups[i].g = bitG[i*groupWidth +: groupWidth];
	end

endmodule

`default_nettype wire

// ==== aluPkg.sv ====
`default_nettype none

package aluPkg;

	// The datapath is fixed by the instruction set
	localparam int dataWidth = 16;
	localparam int groupWidth = 4;
	localparam int groupCount = 4;
	localparam int shiftWidth = 4;

	typedef logic [dataWidth-1:0] dataT;

	// Opcodes 0 to 3 are the shifter, 4 to 7 the adder and logic unit
	typedef enum logic [2:0] {
		opRol = 3'd0,
		opSll = 3'd1,
		opSra = 3'd2,
		opSrl = 3'd3,
		opAdd = 3'd4,
		opOr = 3'd5,
		opXor = 3'd6,
		opAnd = 3'd7
	} aluOpT;

	typedef struct packed {
		dataT a;
		dataT b;
		logic cin;
		aluOpT op;
		logic invA;
		logic invB;
		logic sign;
	} aluReqT;

	// Per-bit propagate and generate of one lookahead group
	typedef struct packed {
		logic [groupWidth-1:0] p;
		logic [groupWidth-1:0] g;
	} pgGroupT;

	typedef struct packed {
		logic [groupWidth-1:0] sum;
		logic groupP;
		logic groupG;
		logic carryOut;
		logic carryIntoTop;
	} groupOutT;

	typedef struct packed {
		dataT out;
		logic ofl;
		logic z;
	} aluRespT;

endpackage

`default_nettype wire
